// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_apb_uart_regs
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/10ps
PASS_TEXT ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/apb_pkg.sv ====
// APB bus widths with the request and response structs of the slave port
`default_nettype none

package apb_pkg;

  //**************************************************************************
  // Bus widths
  //**************************************************************************
  // Eight byte-wide registers on the bus
  localparam int APB_ADDR_WIDTH = 3;
  localparam int APB_DATA_WIDTH = 8;

  typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
  typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

  //**************************************************************************
  // Bus structs
  //**************************************************************************
  // Master to slave, one transfer in flight
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // Slave to master, no pready since the slave never stalls
  typedef struct packed {
    apb_data_t prdata;
    logic      pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// ==== logic/apb_reg_port.sv ====
// APB access-phase decode, slave error decision and read data mux
`timescale 1ns/10ps
`default_nettype none

module apb_reg_port (
  input  apb_pkg::apb_req_t          req,
  output apb_pkg::apb_rsp_t          rsp,
  output uart_regs_pkg::reg_access_t access,
  input  apb_pkg::apb_data_t         cfg_rdata,
  input  apb_pkg::apb_data_t         status_rdata
);

  import apb_pkg::*;
  import uart_regs_pkg::*;

  logic      access_phase;
  logic      mapped;
  logic      read_only;
  logic      cfg_owned;
  logic      legal;
  reg_addr_e addr;

  //**************************************************************************
  // Address decode
  //**************************************************************************
  // Second cycle of the transfer, completes at the next edge
  assign access_phase = req.psel & req.penable;
  assign addr         = reg_addr_e'(req.paddr);

  always_comb begin
    mapped    = 1'b0;
    read_only = 1'b0;
    cfg_owned = 1'b0;
    case (addr)
      // Status group, readable only
      data_status, error_status, rx_data: begin
        mapped    = 1'b1;
        read_only = 1'b1;
      end
      // Config group, read and write
      bit_cr0, bit_cr1, data_cr: begin
        mapped    = 1'b1;
        cfg_owned = 1'b1;
      end
      // Holes in the map
      default: begin
        mapped = 1'b0;
      end
    endcase
  end

  //**************************************************************************
  // Legality and strobes
  //**************************************************************************
  // Any read of a mapped register, or a write to a config register
  assign legal = access_phase & mapped & (~req.pwrite | ~read_only);

  assign access.wr_en = legal & req.pwrite;
  assign access.rd_en = legal & ~req.pwrite;
  assign access.addr  = addr;
  assign access.wdata = req.pwdata;

  //**************************************************************************
  // Response
  //**************************************************************************
  // Error only inside the access phase
  assign rsp.pslverr = access_phase & ~legal;

  // Read data from the group that owns the address, zero otherwise
  always_comb begin
    if (access.rd_en) begin
      rsp.prdata = cfg_owned ? cfg_rdata : status_rdata;
    end else begin
      rsp.prdata = '0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/apb_uart_regs.sv ====
// UART receiver register block top, APB port with config and status groups
`timescale 1ns/10ps
`default_nettype none

module apb_uart_regs #(
  parameter logic [13:0] RESET_BIT_PERIOD = 14'd0,
  parameter logic [3:0]  RESET_DATA_SIZE  = 4'd0
) (
  input  logic                      tb_clk,
  input  logic                      reset,
  input  apb_pkg::apb_req_t         apb_req,
  output apb_pkg::apb_rsp_t         apb_rsp,
  input  uart_regs_pkg::rx_status_t rx,
  output uart_regs_pkg::uart_cfg_t  cfg,
  output logic                      data_read
);

  import apb_pkg::*;
  import uart_regs_pkg::*;

  // Qualified access shared by both groups
  reg_access_t access;
  apb_data_t   cfg_rdata;
  apb_data_t   status_rdata;

  //**************************************************************************
  // Bus side
  //**************************************************************************
  apb_reg_port apb_reg_port_i (
    .req          (apb_req),
    .rsp          (apb_rsp),
    .access       (access),
    .cfg_rdata    (cfg_rdata),
    .status_rdata (status_rdata)
  );

  //**************************************************************************
  // Register groups
  //**************************************************************************
  // Reset values come from the top
  uart_config_regs #(
    .RESET_BIT_PERIOD (RESET_BIT_PERIOD),
    .RESET_DATA_SIZE  (RESET_DATA_SIZE)
  ) uart_config_regs_i (
    .tb_clk (tb_clk),
    .reset  (reset),
    .access (access),
    .cfg    (cfg),
    .rdata  (cfg_rdata)
  );

  rx_status_regs rx_status_regs_i (
    .tb_clk    (tb_clk),
    .reset     (reset),
    .access    (access),
    .rx        (rx),
    .data_read (data_read),
    .rdata     (status_rdata)
  );

endmodule

`default_nettype wire

// ==== logic/rx_status_regs.sv ====
// Sticky receive error flags, data-ready and rx data readback, data_read pulse
`timescale 1ns/10ps
`default_nettype none

module rx_status_regs (
  input  logic                       tb_clk,
  input  logic                       reset,
  input  uart_regs_pkg::reg_access_t access,
  input  uart_regs_pkg::rx_status_t  rx,
  output logic                       data_read,
  output apb_pkg::apb_data_t         rdata
);

  import apb_pkg::*;
  import uart_regs_pkg::*;

  logic framing_flag;
  logic overrun_flag;
  logic clear_errors;
  logic read_rx_data;

  // Legal reads that have a side effect
  assign clear_errors = access.rd_en & (access.addr == error_status);
  assign read_rx_data = access.rd_en & (access.addr == rx_data);

  //**************************************************************************
  // Sticky error flags
  //**************************************************************************
  // New error at the clearing edge wins over the clear
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      framing_flag <= 1'b0;
      overrun_flag <= 1'b0;
    end else begin
      framing_flag <= rx.framing_error | (framing_flag & ~clear_errors);
      overrun_flag <= rx.overrun_error | (overrun_flag & ~clear_errors);
    end
  end

  // One cycle after the rx data read completes
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      data_read <= 1'b0;
    end else begin
      data_read <= read_rx_data;
    end
  end

  //**************************************************************************
  // Readback
  //**************************************************************************
  always_comb begin
    case (access.addr)
      data_status:  rdata = {7'b0000000, rx.data_ready};
      // Bit 0 framing, bit 1 overrun
      error_status: rdata = {6'b000000, overrun_flag, framing_flag};
      rx_data:      rdata = rx.rx_data;
      default:      rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/uart_config_regs.sv ====
// Bit-period and data-size configuration registers with their readback byte
`timescale 1ns/10ps
`default_nettype none

module uart_config_regs #(
  parameter logic [13:0] RESET_BIT_PERIOD = 14'd0,
  parameter logic [3:0]  RESET_DATA_SIZE  = 4'd0
) (
  input  logic                       tb_clk,
  input  logic                       reset,
  input  uart_regs_pkg::reg_access_t access,
  output uart_regs_pkg::uart_cfg_t   cfg,
  output apb_pkg::apb_data_t         rdata
);

  import apb_pkg::*;
  import uart_regs_pkg::*;

  // Low and high halves of the bit period, then the data size
  logic [7:0] bit_lo;
  logic [5:0] bit_hi;
  logic [3:0] size;

  //**************************************************************************
  // Register updates
  //**************************************************************************
  // Each register written on its own, no staging of the two halves
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      bit_lo <= RESET_BIT_PERIOD[7:0];
      bit_hi <= RESET_BIT_PERIOD[13:8];
      size   <= RESET_DATA_SIZE;
    end else if (access.wr_en) begin
      case (access.addr)
        bit_cr0: bit_lo <= access.wdata;
        // Top two write bits dropped
        bit_cr1: bit_hi <= access.wdata[5:0];
        data_cr: size   <= access.wdata[3:0];
        default: ;
      endcase
    end
  end

  // Straight from the registers, new value seen the cycle after the write
  assign cfg.bit_period = {bit_hi, bit_lo};
  assign cfg.data_size  = size;

  //**************************************************************************
  // Readback
  //**************************************************************************
  always_comb begin
    case (access.addr)
      bit_cr0: rdata = bit_lo;
      bit_cr1: rdata = {2'b00, bit_hi};
      data_cr: rdata = {4'b0000, size};
      default: rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/uart_regs_pkg.sv ====
// Register address map, UART config and status structs, decoded register access struct
`default_nettype none

package uart_regs_pkg;

  import apb_pkg::*;

  //**************************************************************************
  // Register map
  //**************************************************************************
  // Addresses 5 and 7 have no register behind them
  typedef enum apb_addr_t {
    data_status  = 3'd0,
    error_status = 3'd1,
    bit_cr0      = 3'd2,
    bit_cr1      = 3'd3,
    data_cr      = 3'd4,
    rx_data      = 3'd6
  } reg_addr_e;

  //**************************************************************************
  // UART side structs
  //**************************************************************************
  localparam int BIT_PERIOD_WIDTH = 14;
  localparam int DATA_SIZE_WIDTH  = 4;

  // Settings handed to the receiver
  typedef struct packed {
    logic [BIT_PERIOD_WIDTH-1:0] bit_period;
    logic [DATA_SIZE_WIDTH-1:0]  data_size;
  } uart_cfg_t;

  // Live status coming back from the receiver
  typedef struct packed {
    apb_data_t rx_data;
    logic      data_ready;
    logic      overrun_error;
    logic      framing_error;
  } rx_status_t;

  // One legal access phase, already qualified by the port
  typedef struct packed {
    logic      wr_en;
    logic      rd_en;
    reg_addr_e addr;
    apb_data_t wdata;
  } reg_access_t;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+verification
logic/apb_pkg.sv
logic/uart_regs_pkg.sv
logic/apb_reg_port.sv
logic/uart_config_regs.sv
logic/rx_status_regs.sv
logic/apb_uart_regs.sv
verification/tb_apb_uart_regs.sv

// ==== verification/apb_uart_model.svh ====
// Reference model of the register map, expected read data, slave errors, config and pulse
`ifndef APB_UART_MODEL_SVH
`define APB_UART_MODEL_SVH

// Expected DUT state, moved forward at the edges the stimulus reports
logic [13:0] exp_bit_period;
logic [3:0]  exp_data_size;
logic        exp_framing;
logic        exp_overrun;
logic        exp_data_read;

// Reads of any mapped register, writes only to the three config registers
function automatic logic is_legal(input logic write, input apb_addr_t addr);
  case (addr)
    data_status, error_status, rx_data: return !write;
    bit_cr0, bit_cr1, data_cr:          return 1'b1;
    default:                            return 1'b0;
  endcase
endfunction

// Byte a legal read returns during its access phase
function automatic apb_data_t expected_rdata(input apb_addr_t addr, input rx_status_t rx_val);
  case (addr)
    data_status:  return {7'b0000000, rx_val.data_ready};
    error_status: return {6'b000000, exp_overrun, exp_framing};
    bit_cr0:      return exp_bit_period[7:0];
    bit_cr1:      return {2'b00, exp_bit_period[13:8]};
    data_cr:      return {4'b0000, exp_data_size};
    rx_data:      return rx_val.rx_data;
    default:      return 8'h00;
  endcase
endfunction

// Full access-phase response, prdata only on legal reads
function automatic apb_rsp_t expected_response(input logic write, input apb_addr_t addr,
                                               input rx_status_t rx_val);
  apb_rsp_t rsp_val;
  rsp_val.pslverr = !is_legal(write, addr);
  rsp_val.prdata  = (is_legal(write, addr) && !write) ? expected_rdata(addr, rx_val) : 8'h00;
  return rsp_val;
endfunction

function automatic uart_cfg_t expected_cfg();
  uart_cfg_t cfg_val;
  cfg_val.bit_period = exp_bit_period;
  cfg_val.data_size  = exp_data_size;
  return cfg_val;
endfunction

task automatic reset_model();
  exp_bit_period = RESET_BIT_PERIOD;
  exp_data_size  = RESET_DATA_SIZE;
  exp_framing    = 1'b0;
  exp_overrun    = 1'b0;
  exp_data_read  = 1'b0;
endtask

// Edge with no completing access, errors still latch
task automatic idle_edge(input rx_status_t rx_val);
  exp_framing   = exp_framing | rx_val.framing_error;
  exp_overrun   = exp_overrun | rx_val.overrun_error;
  exp_data_read = 1'b0;
endtask

// Edge that ends an access phase
task automatic complete_access(input logic write, input apb_addr_t addr,
                               input apb_data_t wdata, input rx_status_t rx_val);
  logic legal;
  logic clear;
  legal = is_legal(write, addr);
  clear = legal && !write && (addr == error_status);
  // A new error beats the clear at the same edge
  exp_framing   = rx_val.framing_error | (exp_framing & !clear);
  exp_overrun   = rx_val.overrun_error | (exp_overrun & !clear);
  exp_data_read = legal && !write && (addr == rx_data);
  if (legal && write) begin
    case (addr)
      bit_cr0: exp_bit_period[7:0]  = wdata;
      // Upper two bits of the high byte dropped
      bit_cr1: exp_bit_period[13:8] = wdata[5:0];
      data_cr: exp_data_size        = wdata[3:0];
      default: ;
    endcase
  end
endtask

`endif

// ==== verification/tb_apb_uart_regs.sv ====
// Testbench for the APB UART register block with random accesses, model and compare tasks
`timescale 1ns/10ps
`default_nettype none

module tb_apb_uart_regs;

  import apb_pkg::*;
  import uart_regs_pkg::*;

  // Nonzero reset values so a missed reset load shows up
  localparam logic [13:0] RESET_BIT_PERIOD = 14'h1a5c;
  localparam logic [3:0]  RESET_DATA_SIZE  = 4'h7;

  localparam int RESET_CYCLES   = 10;
  localparam int NUM_ACCESSES   = 400;
  // Two cycles per access, three budgeted, plus margin
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 3 * NUM_ACCESSES + 50;

  logic        tb_clk;
  logic        reset;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  rx_status_t  rx;
  uart_cfg_t   cfg;
  logic        data_read;

  logic [31:0] rng_state;
  int          rsp_errors;
  int          cfg_errors;
  int          pulse_errors;
  int          access_index;

  `include "apb_uart_model.svh"

  apb_uart_regs #(
    .RESET_BIT_PERIOD (RESET_BIT_PERIOD),
    .RESET_DATA_SIZE  (RESET_DATA_SIZE)
  ) apb_uart_regs_i (
    .tb_clk    (tb_clk),
    .reset     (reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .rx        (rx),
    .cfg       (cfg),
    .data_read (data_read)
  );

  // 10 ns period
  always #5 tb_clk = ~tb_clk;

  //**************************************************************************
  // Random source and compare tasks
  //**************************************************************************
  function automatic logic [31:0] xorshift32(input logic [31:0] value);
    logic [31:0] x;
    x = value;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Errors kept rare so clear-on-read gets exercised
  function automatic rx_status_t rx_from_random(input logic [31:0] r);
    rx_status_t rx_val;
    rx_val.rx_data       = r[19:12];
    rx_val.data_ready    = r[20];
    rx_val.framing_error = (r[24:22] == 3'd0);
    rx_val.overrun_error = (r[27:25] == 3'd0);
    return rx_val;
  endfunction

  task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp);
    if (got.prdata !== exp.prdata) begin
      rsp_errors++;
      $display("FAILED apb_rsp.prdata: got %h expected %h at access %0d",
               got.prdata, exp.prdata, access_index);
    end
    if (got.pslverr !== exp.pslverr) begin
      rsp_errors++;
      $display("FAILED apb_rsp.pslverr: got %h expected %h at access %0d",
               got.pslverr, exp.pslverr, access_index);
    end
  endtask

  task automatic check_cfg(input uart_cfg_t got, input uart_cfg_t exp);
    if (got !== exp) begin
      cfg_errors++;
      $display("FAILED cfg: got %h expected %h at access %0d", got, exp, access_index);
    end
  endtask

  task automatic check_pulse(input logic got, input logic exp);
    if (got !== exp) begin
      pulse_errors++;
      $display("FAILED data_read: got %h expected %h at access %0d", got, exp, access_index);
    end
  endtask

  //**************************************************************************
  // One APB transfer, setup then access phase
  //**************************************************************************
  // Entered just after a rising edge, leaves on the edge ending the access phase
  task automatic do_access(input logic write, input apb_addr_t addr,
                           input apb_data_t wdata, input rx_status_t rx_val);
    #1;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    rx      = rx_val;
    // Setup phase, also the cycle after the previous access
    @(negedge tb_clk);
    check_rsp(apb_rsp, '0);
    check_pulse(data_read, exp_data_read);
    check_cfg(cfg, expected_cfg());
    @(posedge tb_clk);
    idle_edge(rx_val);
    #1;
    apb_req.penable = 1'b1;
    @(negedge tb_clk);
    check_rsp(apb_rsp, expected_response(write, addr, rx_val));
    check_pulse(data_read, exp_data_read);
    @(posedge tb_clk);
    complete_access(write, addr, wdata, rx_val);
  endtask

  //**************************************************************************
  // Main sequence
  //**************************************************************************
  initial begin : stimulus
    logic       write;
    apb_addr_t  addr;
    apb_data_t  wdata;
    rx_status_t rx_next;
    tb_clk       = 1'b0;
    reset        = 1'b1;
    apb_req      = '0;
    rx           = '0;
    rng_state    = 32'h714e;
    rsp_errors   = 0;
    cfg_errors   = 0;
    pulse_errors = 0;
    access_index = 0;
    reset_model();
    repeat (RESET_CYCLES) @(posedge tb_clk);
    #1;
    reset = 1'b0;
    // Reset values and an idle bus
    @(negedge tb_clk);
    check_rsp(apb_rsp, '0);
    check_cfg(cfg, expected_cfg());
    check_pulse(data_read, 1'b0);
    @(posedge tb_clk);
    idle_edge(rx);
    for (access_index = 0; access_index < NUM_ACCESSES; access_index++) begin
      rng_state = xorshift32(rng_state);
      write     = rng_state[0];
      addr      = rng_state[3:1];
      wdata     = rng_state[11:4];
      rx_next   = rx_from_random(rng_state);
      do_access(write, addr, wdata, rx_next);
    end
    // Idle cycle picks up the last config and pulse
    #1;
    apb_req = '0;
    @(negedge tb_clk);
    check_rsp(apb_rsp, '0);
    check_cfg(cfg, expected_cfg());
    check_pulse(data_read, exp_data_read);
    $display("Errors: apb_rsp %0d, cfg %0d, data_read %0d", rsp_errors, cfg_errors,
             pulse_errors);
    if (rsp_errors + cfg_errors + pulse_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog on the cycle count
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge tb_clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
